//--- all.f
common/backend_pkg.sv
rtl/prf.sv
rtl/uop_decoder.sv
rtl/alu_lane.sv
rtl/cdb_result_stage.sv
rtl/int_backend.sv
verif/int_backend_tb.sv

//--- common/backend_pkg.sv
`default_nettype none

package backend_pkg;

    localparam int LANES     = 2;
    localparam int XLEN      = 32;
    localparam int PRF_DEPTH = 64;
    localparam int PHY_W     = 6;
    localparam int ALU_OP_W  = 4;

    // ALU_SLTU must stay the highest code, the ALU range check relies on it
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd9;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // One instruction word seen as either R-type or I-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_u;

endpackage

`default_nettype wire

//--- rtl/alu_lane.sv
`timescale 1ns/1ps
`default_nettype none

module alu_lane (
    input  logic [backend_pkg::ALU_OP_W-1:0]  alu_op,
    input  logic                              use_imm,
    input  logic [backend_pkg::XLEN-1:0]      imm,
    input  logic [backend_pkg::XLEN-1:0]      rs1_value,
    input  logic [backend_pkg::XLEN-1:0]      rs2_value,
    output logic [backend_pkg::XLEN-1:0]      result
);

    logic [backend_pkg::XLEN-1:0] op_b;
    logic [4:0]                   shamt;
    logic                         lt_signed;
    logic                         lt_unsigned;

    assign op_b        = use_imm ? imm : rs2_value;
    assign shamt       = op_b[4:0];
    assign lt_signed   = $signed(rs1_value) < $signed(op_b);
    assign lt_unsigned = rs1_value < op_b;

    always_comb begin
        case (alu_op)
            backend_pkg::ALU_ADD:  result = rs1_value + op_b;
            backend_pkg::ALU_SUB:  result = rs1_value - op_b;
            backend_pkg::ALU_AND:  result = rs1_value & op_b;
            backend_pkg::ALU_OR:   result = rs1_value | op_b;
            backend_pkg::ALU_XOR:  result = rs1_value ^ op_b;
            backend_pkg::ALU_SLL:  result = rs1_value << shamt;
            backend_pkg::ALU_SRL:  result = rs1_value >> shamt;
            backend_pkg::ALU_SRA:  result = $signed(rs1_value) >>> shamt;
            backend_pkg::ALU_SLT:  result = {{(backend_pkg::XLEN - 1){1'b0}}, lt_signed};
            backend_pkg::ALU_SLTU: result = {{(backend_pkg::XLEN - 1){1'b0}}, lt_unsigned};
            default:               result = '0;
        endcase
    end

    // The decoder falls back to ADD for anything it rejects, so no other code should arrive
    always_comb begin
        a_known_op: assert (alu_op <= backend_pkg::ALU_SLTU)
            else $error("alu_lane: undefined alu_op %0d", alu_op);
    end

endmodule

`default_nettype wire

//--- rtl/cdb_result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_result_stage (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           issue_valid [backend_pkg::LANES],
    input  logic                           illegal     [backend_pkg::LANES],
    input  logic [backend_pkg::PHY_W-1:0]  rd_phy      [backend_pkg::LANES],
    input  logic [backend_pkg::XLEN-1:0]   result      [backend_pkg::LANES],

    output logic                           cdb_valid   [backend_pkg::LANES],
    output logic [backend_pkg::PHY_W-1:0]  cdb_rd_phy  [backend_pkg::LANES],
    output logic [backend_pkg::XLEN-1:0]   cdb_value   [backend_pkg::LANES]
);

    always_ff @(posedge clk) begin
        for (int l = 0; l < backend_pkg::LANES; l++) begin
            if (rst) begin
                cdb_valid[l] <= 1'b0;
            end else begin
                cdb_valid[l] <= issue_valid[l] && !illegal[l];
            end
            cdb_rd_phy[l] <= rd_phy[l];
            cdb_value[l]  <= result[l];
        end
    end

    for (genvar l = 0; l < backend_pkg::LANES; l++) begin : g_chk
        // A rejected word never reaches the bus
        a_no_illegal_bcast: assert property (
            @(posedge clk) disable iff (rst)
            illegal[l] |=> !cdb_valid[l]
        ) else $error("cdb_result_stage: lane %0d broadcast an illegal word", l);
    end

endmodule

`default_nettype wire

//--- rtl/int_backend.sv
`timescale 1ns/1ps
`default_nettype none

module int_backend (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           issue_valid   [backend_pkg::LANES],
    input  logic [backend_pkg::XLEN-1:0]   issue_instr   [backend_pkg::LANES],
    input  logic [backend_pkg::PHY_W-1:0]  issue_rs1_phy [backend_pkg::LANES],
    input  logic [backend_pkg::PHY_W-1:0]  issue_rs2_phy [backend_pkg::LANES],
    input  logic [backend_pkg::PHY_W-1:0]  issue_rd_phy  [backend_pkg::LANES],

    output logic                           cdb_valid     [backend_pkg::LANES],
    output logic [backend_pkg::PHY_W-1:0]  cdb_rd_phy    [backend_pkg::LANES],
    output logic [backend_pkg::XLEN-1:0]   cdb_value     [backend_pkg::LANES],
    output logic                           illegal       [backend_pkg::LANES]
);

    logic [backend_pkg::ALU_OP_W-1:0] alu_op    [backend_pkg::LANES];
    logic                             use_imm   [backend_pkg::LANES];
    logic [backend_pkg::XLEN-1:0]     imm       [backend_pkg::LANES];
    logic [backend_pkg::XLEN-1:0]     rs1_value [backend_pkg::LANES];
    logic [backend_pkg::XLEN-1:0]     rs2_value [backend_pkg::LANES];
    logic [backend_pkg::XLEN-1:0]     result    [backend_pkg::LANES];

    for (genvar l = 0; l < backend_pkg::LANES; l++) begin : g_lane
        uop_decoder uop_decoder_i (
            .instr   (issue_instr[l]),
            .valid   (issue_valid[l]),
            .alu_op  (alu_op[l]),
            .use_imm (use_imm[l]),
            .imm     (imm[l]),
            .illegal (illegal[l])
        );

        alu_lane alu_lane_i (
            .alu_op    (alu_op[l]),
            .use_imm   (use_imm[l]),
            .imm       (imm[l]),
            .rs1_value (rs1_value[l]),
            .rs2_value (rs2_value[l]),
            .result    (result[l])
        );
    end

    // The PRF listens to the same CDB that leaves the block
    prf prf_i (
        .clk        (clk),
        .rst        (rst),
        .rd1_phy    (issue_rs1_phy),
        .rd2_phy    (issue_rs2_phy),
        .rd1_value  (rs1_value),
        .rd2_value  (rs2_value),
        .cdb_valid  (cdb_valid),
        .cdb_rd_phy (cdb_rd_phy),
        .cdb_value  (cdb_value)
    );

    cdb_result_stage cdb_result_stage_i (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .illegal     (illegal),
        .rd_phy      (issue_rd_phy),
        .result      (result),
        .cdb_valid   (cdb_valid),
        .cdb_rd_phy  (cdb_rd_phy),
        .cdb_value   (cdb_value)
    );

endmodule

`default_nettype wire

//--- rtl/prf.sv
`timescale 1ns/1ps
`default_nettype none

module prf (
    input  logic                           clk,
    input  logic                           rst,

    input  logic [backend_pkg::PHY_W-1:0]  rd1_phy    [backend_pkg::LANES],
    input  logic [backend_pkg::PHY_W-1:0]  rd2_phy    [backend_pkg::LANES],
    output logic [backend_pkg::XLEN-1:0]   rd1_value  [backend_pkg::LANES],
    output logic [backend_pkg::XLEN-1:0]   rd2_value  [backend_pkg::LANES],

    input  logic                           cdb_valid  [backend_pkg::LANES],
    input  logic [backend_pkg::PHY_W-1:0]  cdb_rd_phy [backend_pkg::LANES],
    input  logic [backend_pkg::XLEN-1:0]   cdb_value  [backend_pkg::LANES]
);

    logic [backend_pkg::XLEN-1:0] regs [backend_pkg::PRF_DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < backend_pkg::PRF_DEPTH; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < backend_pkg::LANES; l++) begin
                if (cdb_valid[l] && (cdb_rd_phy[l] != '0)) begin
                    regs[cdb_rd_phy[l]] <= cdb_value[l];
                end
            end
        end
    end

    // Later lanes overwrite earlier ones, so the highest matching lane wins
    always_comb begin
        for (int j = 0; j < backend_pkg::LANES; j++) begin
            rd1_value[j] = regs[rd1_phy[j]];
            rd2_value[j] = regs[rd2_phy[j]];

            for (int l = 0; l < backend_pkg::LANES; l++) begin
                if (cdb_valid[l] && (cdb_rd_phy[l] == rd1_phy[j])) begin
                    rd1_value[j] = cdb_value[l];
                end
                if (cdb_valid[l] && (cdb_rd_phy[l] == rd2_phy[j])) begin
                    rd2_value[j] = cdb_value[l];
                end
            end

            if (rd1_phy[j] == '0) begin
                rd1_value[j] = '0;
            end
            if (rd2_phy[j] == '0) begin
                rd2_value[j] = '0;
            end
        end
    end

    // Issue must never hand out one destination tag to two lanes at once
    for (genvar a = 0; a < backend_pkg::LANES; a++) begin : g_tag_chk_a
        for (genvar b = a + 1; b < backend_pkg::LANES; b++) begin : g_tag_chk_b
            a_unique_cdb_tag: assert property (
                @(posedge clk) disable iff (rst)
                !(cdb_valid[a] && cdb_valid[b] && (cdb_rd_phy[a] != '0) &&
                  (cdb_rd_phy[a] == cdb_rd_phy[b]))
            ) else $error("prf: CDB lanes %0d and %0d write the same tag", a, b);
        end
    end

endmodule

`default_nettype wire

//--- rtl/uop_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module uop_decoder (
    input  backend_pkg::instr_u                instr,
    input  logic                               valid,
    output logic [backend_pkg::ALU_OP_W-1:0]   alu_op,
    output logic                               use_imm,
    output logic [backend_pkg::XLEN-1:0]       imm,
    output logic                               illegal
);

    logic unsupported;

    // Shift amounts are taken from the low 5 bits inside the ALU
    assign imm = {{(backend_pkg::XLEN - 12){instr.i.imm12[11]}}, instr.i.imm12};

    always_comb begin
        alu_op      = backend_pkg::ALU_ADD;
        use_imm     = 1'b0;
        unsupported = 1'b0;

        case (instr.r.opcode)
            backend_pkg::OPC_OP: begin
                case (instr.r.funct3)
                    3'b000: alu_op = instr.r.funct7[5] ? backend_pkg::ALU_SUB
                                                       : backend_pkg::ALU_ADD;
                    3'b001: alu_op = backend_pkg::ALU_SLL;
                    3'b010: alu_op = backend_pkg::ALU_SLT;
                    3'b011: alu_op = backend_pkg::ALU_SLTU;
                    3'b100: alu_op = backend_pkg::ALU_XOR;
                    3'b101: alu_op = instr.r.funct7[5] ? backend_pkg::ALU_SRA
                                                       : backend_pkg::ALU_SRL;
                    3'b110: alu_op = backend_pkg::ALU_OR;
                    default: alu_op = backend_pkg::ALU_AND;
                endcase
                // Only ADD/SUB and SRL/SRA may set bit 30
                if ((instr.r.funct3 == 3'b000) || (instr.r.funct3 == 3'b101)) begin
                    unsupported = (instr.r.funct7 != 7'b0000000) &&
                                  (instr.r.funct7 != 7'b0100000);
                end else begin
                    unsupported = (instr.r.funct7 != 7'b0000000);
                end
            end
            backend_pkg::OPC_OP_IMM: begin
                use_imm = 1'b1;
                case (instr.i.funct3)
                    3'b000: alu_op = backend_pkg::ALU_ADD;
                    3'b001: begin
                        alu_op      = backend_pkg::ALU_SLL;
                        unsupported = (instr.i.imm12[11:5] != 7'b0000000);
                    end
                    3'b010: alu_op = backend_pkg::ALU_SLT;
                    3'b011: alu_op = backend_pkg::ALU_SLTU;
                    3'b100: alu_op = backend_pkg::ALU_XOR;
                    3'b101: begin
                        alu_op      = instr.i.imm12[10] ? backend_pkg::ALU_SRA
                                                        : backend_pkg::ALU_SRL;
                        unsupported = (instr.i.imm12[11:5] != 7'b0000000) &&
                                      (instr.i.imm12[11:5] != 7'b0100000);
                    end
                    3'b110: alu_op = backend_pkg::ALU_OR;
                    default: alu_op = backend_pkg::ALU_AND;
                endcase
            end
            default: unsupported = 1'b1;
        endcase
    end

    assign illegal = valid && unsupported;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds and runs the int_backend testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module int_backend_tb \
    -f all.f -o int_backend_sim > build.log 2>&1 \
    && ./obj_dir/int_backend_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0

//--- verif/int_backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module int_backend_tb;

    localparam int MAX_TESTS     = 40;
    localparam int RAND_TESTS    = 8;
    localparam int RESET_TIMEOUT = 20;

    logic                          clk;
    logic                          rst;
    logic                          issue_valid   [backend_pkg::LANES];
    logic [backend_pkg::XLEN-1:0]  issue_instr   [backend_pkg::LANES];
    logic [backend_pkg::PHY_W-1:0] issue_rs1_phy [backend_pkg::LANES];
    logic [backend_pkg::PHY_W-1:0] issue_rs2_phy [backend_pkg::LANES];
    logic [backend_pkg::PHY_W-1:0] issue_rd_phy  [backend_pkg::LANES];
    logic                          cdb_valid     [backend_pkg::LANES];
    logic [backend_pkg::PHY_W-1:0] cdb_rd_phy    [backend_pkg::LANES];
    logic [backend_pkg::XLEN-1:0]  cdb_value     [backend_pkg::LANES];
    logic                          illegal       [backend_pkg::LANES];

    // Stimulus table, one row per test and one column per lane
    string                         t_name    [MAX_TESTS];
    logic                          t_valid   [MAX_TESTS][backend_pkg::LANES];
    logic [backend_pkg::XLEN-1:0]  t_instr   [MAX_TESTS][backend_pkg::LANES];
    logic [backend_pkg::PHY_W-1:0] t_rs1     [MAX_TESTS][backend_pkg::LANES];
    logic [backend_pkg::PHY_W-1:0] t_rs2     [MAX_TESTS][backend_pkg::LANES];
    logic [backend_pkg::PHY_W-1:0] t_rd      [MAX_TESTS][backend_pkg::LANES];
    logic                          t_illegal [MAX_TESTS][backend_pkg::LANES];
    logic                          exp_valid [MAX_TESTS][backend_pkg::LANES];
    logic [backend_pkg::XLEN-1:0]  exp_value [MAX_TESTS][backend_pkg::LANES];
    int                            test_err  [MAX_TESTS];

    logic [backend_pkg::XLEN-1:0]  model_regs [backend_pkg::PRF_DEPTH];
    int                            n_tests;
    int                            errors;
    int                            failed_tests;
    int                            seed;

    int_backend int_backend_i (
        .clk           (clk),
        .rst           (rst),
        .issue_valid   (issue_valid),
        .issue_instr   (issue_instr),
        .issue_rs1_phy (issue_rs1_phy),
        .issue_rs2_phy (issue_rs2_phy),
        .issue_rd_phy  (issue_rd_phy),
        .cdb_valid     (cdb_valid),
        .cdb_rd_phy    (cdb_rd_phy),
        .cdb_value     (cdb_value),
        .illegal       (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] funct7,
                                          input logic [2:0] funct3);
        return {funct7, 5'd2, 5'd1, funct3, 5'd3, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm12,
                                          input logic [2:0]  funct3);
        return {imm12, 5'd1, funct3, 5'd3, 7'b0010011};
    endfunction

    function automatic logic [31:0] read_model(input logic [5:0] tag);
        if (tag == 6'd0) begin
            return 32'd0;
        end
        return model_regs[tag];
    endfunction

    // RV32I integer arithmetic, with bit 30 selecting SUB and the arithmetic shifts
    function automatic logic [31:0] ref_result(input logic [31:0] word,
                                               input logic [31:0] a,
                                               input logic [31:0] b);
        logic [31:0] opb;
        logic        alt;
        opb = (word[6:0] == 7'b0010011) ? {{20{word[31]}}, word[31:20]} : b;
        alt = word[30];
        case (word[14:12])
            3'd0: ref_result = (alt && word[6:0] == 7'b0110011) ? a - opb : a + opb;
            3'd1: ref_result = a << opb[4:0];
            3'd2: ref_result = ($signed(a) < $signed(opb)) ? 32'd1 : 32'd0;
            3'd3: ref_result = (a < opb) ? 32'd1 : 32'd0;
            3'd4: ref_result = a ^ opb;
            3'd5: begin
                if (alt) begin
                    ref_result = $signed(a) >>> opb[4:0];
                end else begin
                    ref_result = a >> opb[4:0];
                end
            end
            3'd6: ref_result = a | opb;
            default: ref_result = a & opb;
        endcase
    endfunction

    task automatic begin_entry(input string name);
        t_name[n_tests] = name;
        test_err[n_tests] = 0;
        for (int l = 0; l < backend_pkg::LANES; l++) begin
            t_valid[n_tests][l]   = 1'b0;
            t_instr[n_tests][l]   = '0;
            t_rs1[n_tests][l]     = '0;
            t_rs2[n_tests][l]     = '0;
            t_rd[n_tests][l]      = '0;
            t_illegal[n_tests][l] = 1'b0;
        end
        n_tests++;
    endtask

    task automatic set_lane(input int l, input logic valid, input logic [31:0] word,
                            input int rs1, input int rs2, input int rd, input logic ill);
        t_valid[n_tests-1][l]   = valid;
        t_instr[n_tests-1][l]   = word;
        t_rs1[n_tests-1][l]     = rs1[5:0];
        t_rs2[n_tests-1][l]     = rs2[5:0];
        t_rd[n_tests-1][l]      = rd[5:0];
        t_illegal[n_tests-1][l] = ill;
    endtask

    task automatic build_table();
        int         rnd;
        logic [2:0] f3;
        logic [11:0] imm;
        begin_entry("reset_add");
        set_lane(0, 1'b1, enc_r(7'h00, 3'd0), 5, 6, 10, 1'b0);
        begin_entry("load_imm");
        set_lane(0, 1'b1, enc_i(12'd100, 3'd0), 0, 0, 1, 1'b0);
        set_lane(1, 1'b1, enc_i(12'hff9, 3'd0), 0, 0, 2, 1'b0);
        begin_entry("load_neg");
        set_lane(0, 1'b1, enc_i(12'h800, 3'd0), 0, 0, 3, 1'b0);
        set_lane(1, 1'b1, enc_i(12'h7ff, 3'd0), 0, 0, 4, 1'b0);
        begin_entry("slti_sltiu");
        set_lane(0, 1'b1, enc_i(12'd5, 3'd2), 2, 0, 7, 1'b0);
        set_lane(1, 1'b1, enc_i(12'd5, 3'd3), 2, 0, 8, 1'b0);
        begin_entry("srai_srli");
        set_lane(0, 1'b1, enc_i(12'h401, 3'd5), 2, 0, 9, 1'b0);
        set_lane(1, 1'b1, enc_i(12'h004, 3'd5), 2, 0, 11, 1'b0);
        begin_entry("ori_xori");
        set_lane(0, 1'b1, enc_i(12'h0f0, 3'd6), 1, 0, 12, 1'b0);
        set_lane(1, 1'b1, enc_i(12'hfff, 3'd4), 3, 0, 13, 1'b0);
        begin_entry("andi_slli");
        set_lane(0, 1'b1, enc_i(12'h0ff, 3'd7), 2, 0, 14, 1'b0);
        set_lane(1, 1'b1, enc_i(12'h003, 3'd1), 1, 0, 15, 1'b0);
        begin_entry("add_sub");
        set_lane(0, 1'b1, enc_r(7'h00, 3'd0), 1, 2, 16, 1'b0);
        set_lane(1, 1'b1, enc_r(7'h20, 3'd0), 1, 2, 17, 1'b0);
        begin_entry("and_or");
        set_lane(0, 1'b1, enc_r(7'h00, 3'd7), 2, 4, 18, 1'b0);
        set_lane(1, 1'b1, enc_r(7'h00, 3'd6), 1, 3, 19, 1'b0);
        begin_entry("xor_sll");
        set_lane(0, 1'b1, enc_r(7'h00, 3'd4), 2, 4, 20, 1'b0);
        set_lane(1, 1'b1, enc_r(7'h00, 3'd1), 4, 1, 21, 1'b0);
        begin_entry("srl_sra");
        set_lane(0, 1'b1, enc_r(7'h00, 3'd5), 3, 2, 22, 1'b0);
        set_lane(1, 1'b1, enc_r(7'h20, 3'd5), 3, 2, 23, 1'b0);
        begin_entry("slt_sltu");
        set_lane(0, 1'b1, enc_r(7'h00, 3'd2), 2, 1, 24, 1'b0);
        set_lane(1, 1'b1, enc_r(7'h00, 3'd3), 2, 1, 25, 1'b0);
        // The consumer issues right behind its producers and reads across lanes
        begin_entry("bypass_prod");
        set_lane(0, 1'b1, enc_i(12'd55, 3'd0), 0, 0, 26, 1'b0);
        set_lane(1, 1'b1, enc_i(12'd1, 3'd0), 1, 0, 27, 1'b0);
        begin_entry("bypass_cons");
        set_lane(0, 1'b1, enc_r(7'h00, 3'd0), 26, 27, 28, 1'b0);
        set_lane(1, 1'b1, enc_r(7'h20, 3'd0), 27, 26, 29, 1'b0);
        begin_entry("write_p0");
        set_lane(0, 1'b1, enc_i(12'd123, 3'd0), 0, 0, 0, 1'b0);
        set_lane(1, 1'b1, enc_i(12'd9, 3'd0), 1, 0, 0, 1'b0);
        begin_entry("read_p0");
        set_lane(0, 1'b1, enc_r(7'h00, 3'd0), 0, 0, 30, 1'b0);
        set_lane(1, 1'b1, enc_r(7'h00, 3'd6), 0, 1, 31, 1'b0);
        begin_entry("illegal_op");
        set_lane(0, 1'b1, 32'h0000_007f, 1, 2, 32, 1'b1);
        set_lane(1, 1'b1, enc_r(7'h01, 3'd0), 1, 2, 33, 1'b1);
        begin_entry("illegal_shift");
        set_lane(0, 1'b1, enc_i(12'h020, 3'd1), 1, 0, 34, 1'b1);
        set_lane(1, 1'b0, 32'h0000_007f, 1, 0, 0, 1'b0);
        for (int k = 0; k < RAND_TESTS; k++) begin
            begin_entry($sformatf("rand_%0d", k));
            for (int l = 0; l < backend_pkg::LANES; l++) begin
                rnd = $random(seed);
                f3 = rnd[2:0];
                rnd = $random(seed);
                imm = rnd[11:0];
                if (f3 == 3'd1) begin
                    imm[11:5] = 7'h00;
                end else if (f3 == 3'd5) begin
                    imm[11:5] = imm[11] ? 7'h20 : 7'h00;
                end
                rnd = $random(seed);
                set_lane(l, 1'b1, enc_i(imm, f3), rnd & 31, 0, 40 + 12 * l + k, 1'b0);
            end
        end
    endtask

    task automatic drive_entry(input int i);
        for (int l = 0; l < backend_pkg::LANES; l++) begin
            issue_valid[l]   = t_valid[i][l];
            issue_instr[l]   = t_instr[i][l];
            issue_rs1_phy[l] = t_rs1[i][l];
            issue_rs2_phy[l] = t_rs2[i][l];
            issue_rd_phy[l]  = t_rd[i][l];
            exp_valid[i][l]  = t_valid[i][l] && !t_illegal[i][l];
            exp_value[i][l]  = ref_result(t_instr[i][l], read_model(t_rs1[i][l]),
                                          read_model(t_rs2[i][l]));
        end
        // Both lanes read before either result lands
        for (int l = 0; l < backend_pkg::LANES; l++) begin
            if (exp_valid[i][l] && (t_rd[i][l] != 6'd0)) begin
                model_regs[t_rd[i][l]] = exp_value[i][l];
            end
        end
    endtask

    task automatic drive_idle();
        for (int l = 0; l < backend_pkg::LANES; l++) begin
            issue_valid[l]   = 1'b0;
            issue_instr[l]   = '0;
            issue_rs1_phy[l] = '0;
            issue_rs2_phy[l] = '0;
            issue_rd_phy[l]  = '0;
        end
    endtask

    // Legal words are issued while reset is held, so only the reset keeps the CDB quiet
    task automatic drive_reset_probe();
        for (int l = 0; l < backend_pkg::LANES; l++) begin
            issue_valid[l]   = 1'b1;
            issue_instr[l]   = enc_i(12'd1, 3'd0);
            issue_rs1_phy[l] = '0;
            issue_rs2_phy[l] = '0;
            issue_rd_phy[l]  = l[5:0] + 6'd1;
        end
    endtask

    task automatic check_illegal(input int i);
        for (int l = 0; l < backend_pkg::LANES; l++) begin
            assert (illegal[l] == t_illegal[i][l]) else begin
                $display("mismatch %s lane %0d illegal: expected %0b actual %0b",
                         t_name[i], l, t_illegal[i][l], illegal[l]);
                test_err[i]++;
            end
        end
    endtask

    task automatic check_cdb(input int i);
        for (int l = 0; l < backend_pkg::LANES; l++) begin
            assert (cdb_valid[l] == exp_valid[i][l]) else begin
                $display("mismatch %s lane %0d cdb_valid: expected %0b actual %0b",
                         t_name[i], l, exp_valid[i][l], cdb_valid[l]);
                test_err[i]++;
            end
            if (exp_valid[i][l]) begin
                assert (cdb_rd_phy[l] == t_rd[i][l]) else begin
                    $display("mismatch %s lane %0d cdb_rd_phy: expected %0d actual %0d",
                             t_name[i], l, t_rd[i][l], cdb_rd_phy[l]);
                    test_err[i]++;
                end
                assert (cdb_value[l] == exp_value[i][l]) else begin
                    $display("mismatch %s lane %0d cdb_value: expected %h actual %h",
                             t_name[i], l, exp_value[i][l], cdb_value[l]);
                    test_err[i]++;
                end
            end
        end
        if (test_err[i] == 0) begin
            $display("test %s: ok", t_name[i]);
        end else begin
            $display("test %s: %0d errors", t_name[i], test_err[i]);
            failed_tests++;
        end
        errors += test_err[i];
    endtask

    initial begin
        logic reset_ok;
        int   cycles;
        seed = 32'h0925_cae1;
        errors = 0;
        failed_tests = 0;
        n_tests = 0;
        drive_reset_probe();
        for (int r = 0; r < backend_pkg::PRF_DEPTH; r++) begin
            model_regs[r] = '0;
        end
        build_table();

        // One reset edge has passed with valid words on issue
        @(negedge clk);
        for (int l = 0; l < backend_pkg::LANES; l++) begin
            assert (cdb_valid[l] == 1'b0) else begin
                $display("mismatch in_reset lane %0d cdb_valid: expected 0 actual %0b",
                         l, cdb_valid[l]);
                errors++;
            end
        end
        if (errors == 0) begin
            $display("test in_reset: ok");
        end else begin
            $display("test in_reset: %0d errors", errors);
            failed_tests++;
        end
        drive_idle();

        cycles = 0;
        while ((rst !== 1'b0) && (cycles < RESET_TIMEOUT)) begin
            @(posedge clk);
            cycles++;
        end
        reset_ok = (rst === 1'b0);

        if (!reset_ok) begin
            $display("timeout: reset was not released within %0d cycles", RESET_TIMEOUT);
            $display("STATUS: FAIL");
            $finish;
        end else begin
            @(negedge clk);
            for (int i = 0; i <= n_tests; i++) begin
                if (i > 0) begin
                    check_cdb(i - 1);
                end
                if (i < n_tests) begin
                    drive_entry(i);
                end else begin
                    drive_idle();
                end
                #1;
                if (i < n_tests) begin
                    check_illegal(i);
                end
                @(negedge clk);
            end
            $display("tests run %0d, failed %0d, errors %0d", n_tests + 1, failed_tests,
                     errors);
            if (errors != 0) begin
                $display("STATUS: FAIL");
            end else begin
                $display("STATUS: PASS");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
